//--- design/softmax_pkg.sv
`default_nettype none

package softmax_pkg;

  localparam int VEC_LEN    = 8;
  localparam int IN_WIDTH   = 8;    // signed Q4.4
  localparam int IN_FRAC    = 4;
  localparam int EXP_WIDTH  = 16;   // unsigned Q8.8
  localparam int EXP_FRAC   = 8;
  localparam int SUM_WIDTH  = EXP_WIDTH + $clog2(VEC_LEN);
  localparam int OUT_WIDTH  = 8;    // unsigned Q1.7, 1.0 = 128
  localparam int OUT_FRAC   = 7;
  localparam int FIFO_DEPTH = VEC_LEN;  // one whole vector can wait

  localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int CNT_WIDTH  = $clog2(VEC_LEN + 1);  // also covers FIFO fill level
  localparam int DIV_WIDTH  = EXP_WIDTH + OUT_FRAC + 1;  // scaled dividend

  typedef logic signed [IN_WIDTH-1:0] sample_t;
  typedef logic [EXP_WIDTH-1:0]       exp_t;
  typedef logic [SUM_WIDTH-1:0]       sum_t;
  typedef logic [PTR_WIDTH-1:0]       ptr_t;
  typedef logic [CNT_WIDTH-1:0]       count_t;

  typedef struct packed {
    logic [OUT_WIDTH-1:0] prob;
    logic                 last;  // final beat of a vector
  } out_beat_t;

  // exp of the Q4.4 value encoded by idx, scaled to Q8.8
  function automatic exp_t exp_value(input int unsigned idx);
    int  val;
    real scaled;
    val = (idx >= 2 ** (IN_WIDTH - 1)) ? int'(idx) - 2 ** IN_WIDTH : int'(idx);
    scaled = $exp(real'(val) / real'(2 ** IN_FRAC)) * real'(2 ** EXP_FRAC);
    if (scaled + 0.5 >= real'(2 ** EXP_WIDTH - 1)) begin
      return {EXP_WIDTH{1'b1}};  // saturate
    end
    return exp_t'($rtoi(scaled + 0.5));
  endfunction

endpackage

`default_nettype wire

//--- design/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t mem [softmax_pkg::FIFO_DEPTH];

  softmax_pkg::ptr_t   wr_ptr;
  softmax_pkg::ptr_t   rd_ptr;
  softmax_pkg::count_t count;  // entries held

  logic push;
  logic pop;

  function automatic softmax_pkg::ptr_t ptr_next(input softmax_pkg::ptr_t p);
    return (p == softmax_pkg::ptr_t'(softmax_pkg::FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (count < softmax_pkg::count_t'(softmax_pkg::FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

//--- design/exp_lut.sv
`timescale 1ns/1ps
`default_nettype none

module exp_lut (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  softmax_pkg::sample_t in_sample,
  output logic                out_valid,
  input  logic                out_ready,
  output softmax_pkg::exp_t    out_exp
);

  softmax_pkg::exp_t lut [2 ** softmax_pkg::IN_WIDTH];

  // table built at elaboration, index is the raw sample pattern
  for (genvar i = 0; i < 2 ** softmax_pkg::IN_WIDTH; i++) begin : g_lut
    assign lut[i] = softmax_pkg::exp_value(i);
  end

  // take a new beat when the stage is empty or draining
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) out_exp <= lut[$unsigned(in_sample)];
  end

endmodule

`default_nettype wire

//--- design/exp_sum_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module exp_sum_accumulator (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  softmax_pkg::exp_t in_exp,
  output logic             out_valid,
  input  logic             out_ready,
  output softmax_pkg::sum_t out_sum
);

  softmax_pkg::sum_t   acc;
  softmax_pkg::count_t beat_cnt;  // beats taken of the current vector

  logic              in_fire;
  logic              last_beat;
  softmax_pkg::sum_t acc_next;

  assign in_ready  = !out_valid || out_ready;  // no new input over a pending sum
  assign in_fire   = in_valid && in_ready;
  assign last_beat = (beat_cnt == softmax_pkg::count_t'(softmax_pkg::VEC_LEN - 1));
  assign acc_next  = acc + softmax_pkg::sum_t'(in_exp);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc       <= '0;
      beat_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        acc      <= last_beat ? '0 : acc_next;  // restart for next vector
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
      if (in_fire && last_beat) out_valid <= 1'b1;
      else if (out_ready)       out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire && last_beat) out_sum <= acc_next;
  end

endmodule

`default_nettype wire

//--- design/sum_hold_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sum_hold_buffer (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  softmax_pkg::sum_t in_sum,
  output logic             out_valid,
  input  logic             out_ready,
  output softmax_pkg::sum_t out_sum,
  output logic             out_last
);

  softmax_pkg::count_t reads_left;  // zero means empty
  softmax_pkg::sum_t   held_sum;

  assign in_ready  = (reads_left == '0);
  assign out_valid = (reads_left != '0);
  assign out_last  = (reads_left == softmax_pkg::count_t'(1));
  assign out_sum   = held_sum;

  always_ff @(posedge clk) begin
    if (rst) begin
      reads_left <= '0;
    end else if (in_valid && in_ready) begin
      reads_left <= softmax_pkg::count_t'(softmax_pkg::VEC_LEN);
    end else if (out_valid && out_ready) begin
      reads_left <= reads_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) held_sum <= in_sum;
  end

endmodule

`default_nettype wire

//--- design/softmax_divider.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_divider (
  input  logic                  exp_valid,
  output logic                  exp_ready,
  input  softmax_pkg::exp_t      exp_in,
  input  logic                  sum_valid,
  output logic                  sum_ready,
  input  softmax_pkg::sum_t      sum_in,
  input  logic                  sum_last,
  output logic                  out_valid,
  input  logic                  out_ready,
  output softmax_pkg::out_beat_t out_beat
);

  logic [softmax_pkg::DIV_WIDTH-1:0] dividend;
  logic [softmax_pkg::DIV_WIDTH-1:0] divisor;
  logic [softmax_pkg::DIV_WIDTH-1:0] quotient;  // one extra fraction bit
  logic [softmax_pkg::DIV_WIDTH-1:0] quot_inc;
  logic [softmax_pkg::DIV_WIDTH-2:0] rounded;
  logic                              fire;

  // join, both inputs consumed together with the output
  assign out_valid = exp_valid && sum_valid;
  assign fire      = out_valid && out_ready;
  assign exp_ready = fire;
  assign sum_ready = fire;

  assign dividend = {exp_in, {(softmax_pkg::OUT_FRAC + 1){1'b0}}};
  assign divisor  = {{(softmax_pkg::DIV_WIDTH - softmax_pkg::SUM_WIDTH){1'b0}}, sum_in};

  always_comb begin
    quotient = (sum_in == '0) ? '0 : dividend / divisor;
    quot_inc = quotient + 1'b1;
    rounded  = quot_inc[softmax_pkg::DIV_WIDTH-1:1];  // half-up
    if (sum_in == '0) begin
      out_beat.prob = '0;
    end else if (|rounded[softmax_pkg::DIV_WIDTH-2:softmax_pkg::OUT_WIDTH]) begin
      out_beat.prob = {softmax_pkg::OUT_WIDTH{1'b1}};  // saturate
    end else begin
      out_beat.prob = rounded[softmax_pkg::OUT_WIDTH-1:0];
    end
    out_beat.last = sum_last;
  end

endmodule

`default_nettype wire

//--- design/fixed_softmax.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_softmax (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  softmax_pkg::sample_t   in_sample,
  output logic                  out_valid,
  input  logic                  out_ready,
  output softmax_pkg::out_beat_t out_beat
);

  logic                 smp_valid;
  logic                 smp_ready;
  softmax_pkg::sample_t smp_data;

  logic              lut_valid;
  logic              lut_ready;
  softmax_pkg::exp_t lut_exp;

  logic              efifo_in_valid;
  logic              efifo_in_ready;
  logic              acc_in_valid;
  logic              acc_in_ready;

  logic              efifo_out_valid;
  logic              efifo_out_ready;
  softmax_pkg::exp_t efifo_out_exp;

  logic              acc_out_valid;
  logic              acc_out_ready;
  softmax_pkg::sum_t acc_out_sum;

  logic              hold_valid;
  logic              hold_ready;
  softmax_pkg::sum_t hold_sum;
  logic              hold_last;

  stream_fifo #(
    .payload_t(softmax_pkg::sample_t)
  ) in_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_sample),
    .out_valid(smp_valid),
    .out_ready(smp_ready),
    .out_data (smp_data)
  );

  exp_lut u_exp_lut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (smp_valid),
    .in_ready (smp_ready),
    .in_sample(smp_data),
    .out_valid(lut_valid),
    .out_ready(lut_ready),
    .out_exp  (lut_exp)
  );

  // split, a beat goes to both consumers or to neither
  assign efifo_in_valid = lut_valid && acc_in_ready;
  assign acc_in_valid   = lut_valid && efifo_in_ready;
  assign lut_ready      = efifo_in_ready && acc_in_ready;

  stream_fifo #(
    .payload_t(softmax_pkg::exp_t)
  ) exp_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (efifo_in_valid),
    .in_ready (efifo_in_ready),
    .in_data  (lut_exp),
    .out_valid(efifo_out_valid),
    .out_ready(efifo_out_ready),
    .out_data (efifo_out_exp)
  );

  exp_sum_accumulator u_accumulator (
    .clk      (clk),
    .rst      (rst),
    .in_valid (acc_in_valid),
    .in_ready (acc_in_ready),
    .in_exp   (lut_exp),
    .out_valid(acc_out_valid),
    .out_ready(acc_out_ready),
    .out_sum  (acc_out_sum)
  );

  sum_hold_buffer u_hold (
    .clk      (clk),
    .rst      (rst),
    .in_valid (acc_out_valid),
    .in_ready (acc_out_ready),
    .in_sum   (acc_out_sum),
    .out_valid(hold_valid),
    .out_ready(hold_ready),
    .out_sum  (hold_sum),
    .out_last (hold_last)
  );

  softmax_divider u_divider (
    .exp_valid(efifo_out_valid),
    .exp_ready(efifo_out_ready),
    .exp_in   (efifo_out_exp),
    .sum_valid(hold_valid),
    .sum_ready(hold_ready),
    .sum_in   (hold_sum),
    .sum_last (hold_last),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_beat (out_beat)
  );

endmodule

`default_nettype wire

//--- verification/softmax_properties.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_properties (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input softmax_pkg::out_beat_t out_beat,
  input softmax_pkg::ptr_t      efifo_wr_ptr,  // moves on every exp_fifo write
  input softmax_pkg::count_t    acc_beat_cnt   // moves on every accumulator beat
);

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_beat))
    else $error("out_beat changed while the output was stalled");

  a_out_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped without a transfer");

  // fifos are empty right after reset
  a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
    else $error("in_ready low in the first cycle after reset");

  // both consumers step their own state on the same beats
  a_split_both: assert property (@(posedge clk) disable iff (rst)
    $changed(efifo_wr_ptr) == $changed(acc_beat_cnt))
    else $error("exponential beat taken by only one consumer");

endmodule

bind fixed_softmax softmax_properties props (
  .clk          (clk),
  .rst          (rst),
  .in_ready     (in_ready),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_beat     (out_beat),
  .efifo_wr_ptr (exp_fifo.wr_ptr),
  .acc_beat_cnt (u_accumulator.beat_cnt)
);

`default_nettype wire

//--- verification/softmax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_tb;

  localparam int NUM_VEC  = 11;    // lines in the data file
  localparam int BEAT_MAX = 1000;  // cycles allowed per wait
  localparam logic [31:0] SEED = 32'd60423;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  logic                   in_ready;
  softmax_pkg::sample_t   in_sample;
  logic                   out_valid;
  logic                   out_ready;
  softmax_pkg::out_beat_t out_beat;

  // per vector: samples then expected probabilities
  logic [7:0]  tdata [0:NUM_VEC*2*softmax_pkg::VEC_LEN-1];
  logic [31:0] gap_state;
  logic [31:0] ready_state;

  fixed_softmax dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_sample(in_sample),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_beat (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_prob(input string name,
                            input logic [softmax_pkg::OUT_WIDTH-1:0] expected,
                            input logic [softmax_pkg::OUT_WIDTH-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s expected 0x%02h actual 0x%02h", name, expected, actual));
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  // handshake flags
  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  task automatic send_vectors(input bit gaps);
    int waited;
    int gap_len;
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int s = 0; s < softmax_pkg::VEC_LEN; s++) begin
        if (gaps) begin
          gap_state = xorshift32(gap_state);
          gap_len   = int'(gap_state[1:0]);
          in_valid  = 1'b0;
          repeat (gap_len) @(negedge clk);
        end
        in_valid  = 1'b1;
        in_sample = softmax_pkg::sample_t'(tdata[v * 2 * softmax_pkg::VEC_LEN + s]);
        waited    = 0;
        while (!in_ready) begin
          @(negedge clk);
          waited++;
          if (waited > BEAT_MAX) abort_run("in_ready stayed low for too long");
        end
        @(negedge clk);  // taken on the rising edge just passed
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic receive_vectors(input string tag, input bit stall);
    int         waited;
    logic [7:0] want;
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int s = 0; s < softmax_pkg::VEC_LEN; s++) begin
        waited = 0;
        do begin
          @(negedge clk);
          if (stall) begin
            ready_state = xorshift32(ready_state);
            out_ready   = ready_state[7];
          end else begin
            out_ready = 1'b1;
          end
          waited++;
          if (waited > BEAT_MAX) abort_run("no output beat arrived in time");
        end while (!(out_valid && out_ready));
        want = tdata[v * 2 * softmax_pkg::VEC_LEN + softmax_pkg::VEC_LEN + s];
        check_prob($sformatf("%s vec %0d beat %0d prob", tag, v, s), want, out_beat.prob);
        check_last($sformatf("%s vec %0d beat %0d last", tag, v, s),
                   s == softmax_pkg::VEC_LEN - 1, out_beat.last);
      end
    end
  endtask

  task automatic run_pass(input string tag, input bit stall);
    fork
      send_vectors(stall);
      receive_vectors(tag, stall);
    join
    out_ready = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_flag({tag, " no extra output"}, 1'b0, out_valid);  // nothing duplicated
    end
  endtask

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_sample   = '0;
    out_ready   = 1'b0;
    gap_state   = SEED;
    ready_state = xorshift32(SEED ^ 32'h5bd1e995);
    $readmemh("verification/softmax_testdata.txt", tdata);

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset out_valid", 1'b0, out_valid);
    check_flag("reset in_ready", 1'b1, in_ready);

    run_pass("steady", 1'b0);
    run_pass("stalled", 1'b1);  // gaps and output back-pressure

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/softmax_testdata.txt
// columns: 8 input samples (signed Q4.4), then 8 expected probabilities (Q1.7), all hex
// probability = (floor(exp * 256 / sum) + 1) / 2 with exp from the Q8.8 table
// ordinary vectors
00 00 00 00 00 00 00 00  10 10 10 10 10 10 10 10
00 10 20 f0 00 10 20 f0  06 0f 29 02 06 0f 29 02
30 00 00 00 00 00 00 00  5f 05 05 05 05 05 05 05
40 08 e0 c0 f8 18 00 10  6b 03 00 00 01 09 02 05
50 40 30 20 10 00 f0 e0  51 1e 0b 04 01 01 00 00
// saturating large inputs
7f 80 80 80 80 80 80 80  80 00 00 00 00 00 00 00
70 70 70 70 70 70 70 70  10 10 10 10 10 10 10 10
60 80 70 88 80 90 80 80  40 00 40 00 00 00 00 00
7f 00 00 00 00 00 00 00  7d 00 00 00 00 00 00 00
// all exponentials zero, sum is zero
80 80 80 80 80 80 80 80  00 00 00 00 00 00 00 00
88 90 98 80 88 90 98 80  00 00 00 00 00 00 00 00

//--- flist.f
design/softmax_pkg.sv
design/stream_fifo.sv
design/exp_lut.sv
design/exp_sum_accumulator.sv
design/sum_hold_buffer.sv
design/softmax_divider.sv
design/fixed_softmax.sv
verification/softmax_properties.sv
verification/softmax_tb.sv

//--- Makefile
# Verilator build and run for the softmax engine

VERILATOR ?= verilator
TOP       ?= softmax_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXE       ?= V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS EXE"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(EXE)
	./$(BUILD_DIR)/$(EXE)

clean:
	rm -rf $(BUILD_DIR)
